//--- src/axi_bus_pkg.sv
// AXI4 bus package
// widths, burst, size and response codes shared by the miss path

`default_nettype none

package axi_bus_pkg;

    // bus widths
    localparam int AXI_ADDR_W = 32;
    localparam int AXI_DATA_W = 32;
    localparam int AXI_STRB_W = AXI_DATA_W / 8;
    localparam int AXI_LEN_W  = 8;   // AXI4 burst length field

    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } axi_burst_t;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axi_resp_t;

    // four bytes per beat
    localparam logic [2:0] SIZE_WORD = 3'b010;

endpackage

`default_nettype wire

//--- src/cache_req_pkg.sv
// cache request package
// requester identity and the arbiter's read and write FSM states

`default_nettype none

package cache_req_pkg;

    // which cache owns the current read burst
    typedef enum logic {
        REQ_ICACHE = 1'b0,
        REQ_DCACHE = 1'b1
    } requester_t;

    typedef enum logic [1:0] {
        RD_IDLE = 2'd0,
        RD_ADDR = 2'd1,   // arvalid up, waiting on arready
        RD_DATA = 2'd2    // rready up until rlast
    } rd_state_t;

    typedef enum logic [1:0] {
        WR_IDLE = 2'd0,
        WR_ADDR = 2'd1,
        WR_DATA = 2'd2,
        WR_RESP = 2'd3
    } wr_state_t;

endpackage

`default_nettype wire

//--- src/beat_ifs.sv
// beat interfaces between the arbiter and the line buffers
// rd_beat_if carries accepted R beats, wr_beat_if carries W beat control

`timescale 1ns/100ps
`default_nettype none

interface rd_beat_if;
    import axi_bus_pkg::*;
    import cache_req_pkg::*;

    logic                  beat_valid;   // beat accepted this cycle
    logic                  beat_last;
    logic [AXI_DATA_W-1:0] beat_data;
    axi_resp_t             beat_resp;
    requester_t            owner;

    modport ctrl (output beat_valid, beat_last, beat_data, beat_resp, owner);
    modport buffer (input beat_valid, beat_last, beat_data, beat_resp, owner);
endinterface

interface wr_beat_if;
    import axi_bus_pkg::*;

    logic [AXI_DATA_W-1:0] beat_data;   // current W word
    logic                  beat_last;
    logic                  beat_take;   // wvalid and wready both high
    logic                  load;        // capture writeback line
    logic                  resp_done;   // B handshake
    axi_resp_t             resp;

    modport ctrl (
        input  beat_data, beat_last,
        output beat_take, load, resp_done, resp
    );
    modport buffer (
        output beat_data, beat_last,
        input  beat_take, load, resp_done, resp
    );
endinterface

`default_nettype wire

//--- src/axi_arbiter.sv
// AXI miss arbiter
// independent read and write FSMs driving one AXI4 master port,
// dcache has read priority over icache, bursts are fixed INCR line fills

`timescale 1ns/100ps
`default_nettype none

module axi_arbiter #(
    parameter int LINE_WORDS = 4
) (
    input  logic                                clk,
    input  logic                                rstn,
    // cache requests
    input  logic                                i_ic_req,
    input  logic [axi_bus_pkg::AXI_ADDR_W-1:0]  i_ic_addr,
    input  logic                                i_dc_rd_req,
    input  logic [axi_bus_pkg::AXI_ADDR_W-1:0]  i_dc_rd_addr,
    input  logic                                i_dc_wb_req,
    input  logic [axi_bus_pkg::AXI_ADDR_W-1:0]  i_dc_wb_addr,
    // AR
    output logic [axi_bus_pkg::AXI_ADDR_W-1:0]  o_araddr,
    output logic                                o_arvalid,
    output logic [axi_bus_pkg::AXI_LEN_W-1:0]   o_arlen,
    output logic [2:0]                          o_arsize,
    output axi_bus_pkg::axi_burst_t             o_arburst,
    input  logic                                i_arready,
    // R
    input  logic [axi_bus_pkg::AXI_DATA_W-1:0]  i_rdata,
    input  axi_bus_pkg::axi_resp_t              i_rresp,
    input  logic                                i_rvalid,
    input  logic                                i_rlast,
    output logic                                o_rready,
    // AW
    output logic [axi_bus_pkg::AXI_ADDR_W-1:0]  o_awaddr,
    output logic                                o_awvalid,
    output logic [axi_bus_pkg::AXI_LEN_W-1:0]   o_awlen,
    output logic [2:0]                          o_awsize,
    output axi_bus_pkg::axi_burst_t             o_awburst,
    input  logic                                i_awready,
    // W control, data comes from the write buffer
    output logic                                o_wvalid,
    input  logic                                i_wready,
    // B
    input  axi_bus_pkg::axi_resp_t              i_bresp,
    input  logic                                i_bvalid,
    output logic                                o_bready,
    // beat traffic
    rd_beat_if.ctrl                             rd,
    wr_beat_if.ctrl                             wr
);
    import axi_bus_pkg::*;
    import cache_req_pkg::*;

    localparam logic [AXI_LEN_W-1:0] BURST_LEN = AXI_LEN_W'(LINE_WORDS - 1);

    rd_state_t             rd_state, rd_next;
    wr_state_t             wr_state, wr_next;
    requester_t            owner_q;
    logic [AXI_ADDR_W-1:0] araddr_q;
    logic [AXI_ADDR_W-1:0] awaddr_q;
    logic                  rd_end_q;   // fill done pulse still on its way out
    logic                  wr_end_q;
    logic                  rd_start;
    logic                  rd_take;
    logic                  wr_start;
    logic                  wr_take;

    // the finished cache still holds its request while done is pulsing,
    // so skip sampling for that one cycle
    assign rd_start = (rd_state == RD_IDLE) && !rd_end_q && (i_dc_rd_req || i_ic_req);
    assign rd_take  = (rd_state == RD_DATA) && i_rvalid;
    assign wr_start = (wr_state == WR_IDLE) && !wr_end_q && i_dc_wb_req;
    assign wr_take  = (wr_state == WR_DATA) && i_wready;

    // read FSM
    always_comb begin
        rd_next = rd_state;
        case (rd_state)
            RD_IDLE: if (rd_start)            rd_next = RD_ADDR;
            RD_ADDR: if (i_arready)           rd_next = RD_DATA;
            RD_DATA: if (rd_take && i_rlast)  rd_next = RD_IDLE;
            default:                          rd_next = RD_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rd_state <= RD_IDLE;
            owner_q  <= REQ_ICACHE;
            rd_end_q <= 1'b0;
        end else begin
            rd_state <= rd_next;
            rd_end_q <= rd_take && i_rlast;
            if (rd_start)
                owner_q <= i_dc_rd_req ? REQ_DCACHE : REQ_ICACHE;   // dcache first
        end
    end

    // address held for the whole burst
    always_ff @(posedge clk) begin
        if (rd_start)
            araddr_q <= i_dc_rd_req ? i_dc_rd_addr : i_ic_addr;
        if (wr_start)
            awaddr_q <= i_dc_wb_addr;
    end

    assign o_araddr  = araddr_q;
    assign o_arvalid = (rd_state == RD_ADDR);
    assign o_arlen   = BURST_LEN;
    assign o_arsize  = SIZE_WORD;
    assign o_arburst = BURST_INCR;
    assign o_rready  = (rd_state == RD_DATA);   // never withheld

    // accepted beats go straight to the return buffer
    assign rd.beat_valid = rd_take;
    assign rd.beat_last  = i_rlast;
    assign rd.beat_data  = i_rdata;
    assign rd.beat_resp  = i_rresp;
    assign rd.owner      = owner_q;

    // write FSM
    always_comb begin
        wr_next = wr_state;
        case (wr_state)
            WR_IDLE: if (wr_start)                  wr_next = WR_ADDR;
            WR_ADDR: if (i_awready)                 wr_next = WR_DATA;
            WR_DATA: if (wr_take && wr.beat_last)   wr_next = WR_RESP;
            WR_RESP: if (i_bvalid)                  wr_next = WR_IDLE;
            default:                                wr_next = WR_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_state <= WR_IDLE;
            wr_end_q <= 1'b0;
        end else begin
            wr_state <= wr_next;
            wr_end_q <= (wr_state == WR_RESP) && i_bvalid;
        end
    end

    assign o_awaddr  = awaddr_q;
    assign o_awvalid = (wr_state == WR_ADDR);
    assign o_awlen   = BURST_LEN;
    assign o_awsize  = SIZE_WORD;
    assign o_awburst = BURST_INCR;
    assign o_wvalid  = (wr_state == WR_DATA);
    assign o_bready  = (wr_state == WR_RESP);

    assign wr.load      = wr_start;
    assign wr.beat_take = wr_take;
    assign wr.resp_done = (wr_state == WR_RESP) && i_bvalid;
    assign wr.resp      = i_bresp;

endmodule

`default_nettype wire

//--- src/return_buffer.sv
// read return buffer
// packs R beats into a line for the owning cache, pulses its done
// the cycle after the last beat and flags error responses

`timescale 1ns/100ps
`default_nettype none

module return_buffer #(
    parameter int LINE_WORDS = 4
) (
    input  logic                                          clk,
    input  logic                                          rstn,
    rd_beat_if.buffer                                     rd,
    output logic [LINE_WORDS*axi_bus_pkg::AXI_DATA_W-1:0] o_ic_line,
    output logic                                          o_ic_done,
    output logic [LINE_WORDS*axi_bus_pkg::AXI_DATA_W-1:0] o_dc_line,
    output logic                                          o_dc_done,
    output logic                                          o_rd_err
);
    import axi_bus_pkg::*;
    import cache_req_pkg::*;

    localparam int IDX_W = $clog2(LINE_WORDS);

    logic [IDX_W-1:0]                       beat_idx;
    logic [LINE_WORDS-1:0][AXI_DATA_W-1:0]  stage_q;
    logic [LINE_WORDS-1:0][AXI_DATA_W-1:0]  stage_next;
    logic                                   line_end;

    assign line_end = rd.beat_valid && rd.beat_last;

    // current beat merged into the staging line, word 0 lowest
    always_comb begin
        stage_next           = stage_q;
        stage_next[beat_idx] = rd.beat_data;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            beat_idx  <= '0;
            o_ic_done <= 1'b0;
            o_dc_done <= 1'b0;
            o_rd_err  <= 1'b0;
        end else begin
            if (rd.beat_valid)
                beat_idx <= rd.beat_last ? '0 : beat_idx + 1'b1;
            o_ic_done <= line_end && (rd.owner == REQ_ICACHE);
            o_dc_done <= line_end && (rd.owner == REQ_DCACHE);
            o_rd_err  <= rd.beat_valid &&
                         (rd.beat_resp == RESP_SLVERR || rd.beat_resp == RESP_DECERR);
        end
    end

    // line outputs hold until the same cache's next fill completes
    always_ff @(posedge clk) begin
        if (rd.beat_valid)
            stage_q <= stage_next;
        if (line_end && rd.owner == REQ_ICACHE)
            o_ic_line <= stage_next;
        if (line_end && rd.owner == REQ_DCACHE)
            o_dc_line <= stage_next;
    end

endmodule

`default_nettype wire

//--- src/write_buffer.sv
// writeback buffer
// holds one dirty line and presents it word by word on the W channel,
// wlast from the beat counter, done and error after the B handshake

`timescale 1ns/100ps
`default_nettype none

module write_buffer #(
    parameter int LINE_WORDS = 4
) (
    input  logic                                          clk,
    input  logic                                          rstn,
    wr_beat_if.buffer                                     wr,
    input  logic [LINE_WORDS*axi_bus_pkg::AXI_DATA_W-1:0] i_wb_line,
    output logic [axi_bus_pkg::AXI_DATA_W-1:0]            o_wdata,
    output logic [axi_bus_pkg::AXI_STRB_W-1:0]            o_wstrb,
    output logic                                          o_wb_done,
    output logic                                          o_wr_err
);
    import axi_bus_pkg::*;

    localparam int IDX_W = $clog2(LINE_WORDS);

    logic [LINE_WORDS-1:0][AXI_DATA_W-1:0]  line_q;
    logic [IDX_W-1:0]                       beat_cnt;

    // counter picks the word, wlast only while the final word is up
    assign wr.beat_data = line_q[beat_cnt];
    assign wr.beat_last = (beat_cnt == IDX_W'(LINE_WORDS - 1));

    assign o_wdata = wr.beat_data;
    assign o_wstrb = '1;   // full-line writes only

    always_ff @(posedge clk) begin
        if (wr.load)
            line_q <= i_wb_line;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            beat_cnt  <= '0;
            o_wb_done <= 1'b0;
            o_wr_err  <= 1'b0;
        end else begin
            if (wr.load)
                beat_cnt <= '0;
            else if (wr.beat_take)
                beat_cnt <= wr.beat_last ? '0 : beat_cnt + 1'b1;   // park at 0 after last
            o_wb_done <= wr.resp_done;
            o_wr_err  <= wr.resp_done &&
                         (wr.resp == RESP_SLVERR || wr.resp == RESP_DECERR);
        end
    end

endmodule

`default_nettype wire

//--- src/l1_miss_axi.sv
// L1 miss path top
// icache and dcache line fills plus dcache writeback onto one AXI4 port,
// with a sticky bus error flag

`timescale 1ns/100ps
`default_nettype none

module l1_miss_axi #(
    parameter int LINE_WORDS = 4
) (
    input  logic                                          clk,
    input  logic                                          rstn,
    // icache
    input  logic                                          i_ic_req,
    input  logic [axi_bus_pkg::AXI_ADDR_W-1:0]            i_ic_addr,
    output logic [LINE_WORDS*axi_bus_pkg::AXI_DATA_W-1:0] o_ic_line,
    output logic                                          o_ic_done,
    // dcache read
    input  logic                                          i_dc_rd_req,
    input  logic [axi_bus_pkg::AXI_ADDR_W-1:0]            i_dc_rd_addr,
    output logic [LINE_WORDS*axi_bus_pkg::AXI_DATA_W-1:0] o_dc_line,
    output logic                                          o_dc_done,
    // dcache writeback
    input  logic                                          i_dc_wb_req,
    input  logic [axi_bus_pkg::AXI_ADDR_W-1:0]            i_dc_wb_addr,
    input  logic [LINE_WORDS*axi_bus_pkg::AXI_DATA_W-1:0] i_dc_wb_line,
    output logic                                          o_dc_wb_done,
    output logic                                          o_bus_err,
    // AR
    output logic [axi_bus_pkg::AXI_ADDR_W-1:0]            o_araddr,
    output logic                                          o_arvalid,
    output logic [axi_bus_pkg::AXI_LEN_W-1:0]             o_arlen,
    output logic [2:0]                                    o_arsize,
    output axi_bus_pkg::axi_burst_t                       o_arburst,
    input  logic                                          i_arready,
    // R
    input  logic [axi_bus_pkg::AXI_DATA_W-1:0]            i_rdata,
    input  axi_bus_pkg::axi_resp_t                        i_rresp,
    input  logic                                          i_rvalid,
    input  logic                                          i_rlast,
    output logic                                          o_rready,
    // AW
    output logic [axi_bus_pkg::AXI_ADDR_W-1:0]            o_awaddr,
    output logic                                          o_awvalid,
    output logic [axi_bus_pkg::AXI_LEN_W-1:0]             o_awlen,
    output logic [2:0]                                    o_awsize,
    output axi_bus_pkg::axi_burst_t                       o_awburst,
    input  logic                                          i_awready,
    // W
    output logic [axi_bus_pkg::AXI_DATA_W-1:0]            o_wdata,
    output logic [axi_bus_pkg::AXI_STRB_W-1:0]            o_wstrb,
    output logic                                          o_wlast,
    output logic                                          o_wvalid,
    input  logic                                          i_wready,
    // B
    input  axi_bus_pkg::axi_resp_t                        i_bresp,
    input  logic                                          i_bvalid,
    output logic                                          o_bready
);
    logic rd_err;
    logic wr_err;

    rd_beat_if rd_beats ();
    wr_beat_if wr_beats ();

    axi_arbiter #(
        .LINE_WORDS (LINE_WORDS)
    ) u_arbiter (
        .clk          (clk),
        .rstn         (rstn),
        .i_ic_req     (i_ic_req),
        .i_ic_addr    (i_ic_addr),
        .i_dc_rd_req  (i_dc_rd_req),
        .i_dc_rd_addr (i_dc_rd_addr),
        .i_dc_wb_req  (i_dc_wb_req),
        .i_dc_wb_addr (i_dc_wb_addr),
        .o_araddr     (o_araddr),
        .o_arvalid    (o_arvalid),
        .o_arlen      (o_arlen),
        .o_arsize     (o_arsize),
        .o_arburst    (o_arburst),
        .i_arready    (i_arready),
        .i_rdata      (i_rdata),
        .i_rresp      (i_rresp),
        .i_rvalid     (i_rvalid),
        .i_rlast      (i_rlast),
        .o_rready     (o_rready),
        .o_awaddr     (o_awaddr),
        .o_awvalid    (o_awvalid),
        .o_awlen      (o_awlen),
        .o_awsize     (o_awsize),
        .o_awburst    (o_awburst),
        .i_awready    (i_awready),
        .o_wvalid     (o_wvalid),
        .i_wready     (i_wready),
        .i_bresp      (i_bresp),
        .i_bvalid     (i_bvalid),
        .o_bready     (o_bready),
        .rd           (rd_beats.ctrl),
        .wr           (wr_beats.ctrl)
    );

    return_buffer #(
        .LINE_WORDS (LINE_WORDS)
    ) u_return_buffer (
        .clk       (clk),
        .rstn      (rstn),
        .rd        (rd_beats.buffer),
        .o_ic_line (o_ic_line),
        .o_ic_done (o_ic_done),
        .o_dc_line (o_dc_line),
        .o_dc_done (o_dc_done),
        .o_rd_err  (rd_err)
    );

    write_buffer #(
        .LINE_WORDS (LINE_WORDS)
    ) u_write_buffer (
        .clk       (clk),
        .rstn      (rstn),
        .wr        (wr_beats.buffer),
        .i_wb_line (i_dc_wb_line),
        .o_wdata   (o_wdata),
        .o_wstrb   (o_wstrb),
        .o_wb_done (o_dc_wb_done),
        .o_wr_err  (wr_err)
    );

    assign o_wlast = wr_beats.beat_last;

    // sticky until reset
    always_ff @(posedge clk) begin
        if (!rstn)
            o_bus_err <= 1'b0;
        else if (rd_err || wr_err)
            o_bus_err <= 1'b1;
    end

endmodule

`default_nettype wire

//--- tests/axi_arbiter_properties.sv
// AXI handshake properties for the miss arbiter
// bound into axi_arbiter, valids hold with stable payload until ready

`timescale 1ns/100ps
`default_nettype none

module axi_arbiter_properties (
    input  logic                               clk,
    input  logic                               rstn,
    input  logic                               i_arvalid,
    input  logic                               i_arready,
    input  logic [axi_bus_pkg::AXI_ADDR_W-1:0] i_araddr,
    input  logic                               i_awvalid,
    input  logic                               i_awready,
    input  logic [axi_bus_pkg::AXI_ADDR_W-1:0] i_awaddr,
    input  logic                               i_wvalid,
    input  logic                               i_wready,
    input  logic [axi_bus_pkg::AXI_DATA_W-1:0] i_wdata,
    input  logic                               i_wlast,
    input  logic                               i_rvalid,
    input  logic                               i_rlast,
    input  cache_req_pkg::rd_state_t           i_rd_state,
    input  cache_req_pkg::wr_state_t           i_wr_state
);
    import cache_req_pkg::*;

    ar_hold: assert property (@(posedge clk) disable iff (!rstn)
        i_arvalid && !i_arready |=> i_arvalid && $stable(i_araddr))
        else $error("arvalid dropped or araddr moved before arready");

    aw_hold: assert property (@(posedge clk) disable iff (!rstn)
        i_awvalid && !i_awready |=> i_awvalid && $stable(i_awaddr))
        else $error("awvalid dropped or awaddr moved before awready");

    // data and wlast both part of the W payload
    w_hold: assert property (@(posedge clk) disable iff (!rstn)
        i_wvalid && !i_wready |=> i_wvalid && $stable(i_wdata) && $stable(i_wlast))
        else $error("wvalid dropped or W payload moved before wready");

    wlast_in_data: assert property (@(posedge clk) disable iff (!rstn)
        i_wlast |-> i_wr_state == WR_DATA)
        else $error("wlast high outside the W data phase");

    rd_exit_on_rlast: assert property (@(posedge clk) disable iff (!rstn)
        i_rd_state == RD_DATA && !(i_rvalid && i_rlast) |=> i_rd_state == RD_DATA)
        else $error("read FSM left the data phase without an rlast beat");

endmodule

bind axi_arbiter axi_arbiter_properties u_properties (
    .clk        (clk),
    .rstn       (rstn),
    .i_arvalid  (o_arvalid),
    .i_arready  (i_arready),
    .i_araddr   (o_araddr),
    .i_awvalid  (o_awvalid),
    .i_awready  (i_awready),
    .i_awaddr   (o_awaddr),
    .i_wvalid   (o_wvalid),
    .i_wready   (i_wready),
    .i_wdata    (wr.beat_data),
    .i_wlast    (wr.beat_last),
    .i_rvalid   (i_rvalid),
    .i_rlast    (i_rlast),
    .i_rd_state (rd_state),
    .i_wr_state (wr_state)
);

`default_nettype wire

//--- tests/tb_l1_miss_axi.sv
// testbench for the L1 miss path
// AXI slave memory model with random stalls, directed fill, priority,
// writeback, parallel and error-response tests

`timescale 1ns/100ps
`default_nettype none

module tb_l1_miss_axi;
    import axi_bus_pkg::*;

    localparam int LINE_WORDS  = 4;
    localparam int LINE_W      = LINE_WORDS * AXI_DATA_W;
    localparam int MEM_AW      = 8;   // 256 words of model memory
    localparam int MEM_WORDS   = 1 << MEM_AW;
    localparam logic [31:0] MEM_KEY = 32'h5a3c_96e1;
    localparam int NUM_TESTS   = 5;
    localparam int TEST_CYCLES = 2000;
    localparam int DONE_IC     = 0;
    localparam int DONE_DC     = 1;
    localparam int DONE_WB     = 2;

    typedef logic [AXI_ADDR_W-1:0] addr_t;
    typedef logic [AXI_DATA_W-1:0] word_t;
    typedef logic [LINE_W-1:0]     line_t;
    typedef logic [MEM_AW-1:0]     idx_t;

    logic clk;
    logic rstn;
    logic i_ic_req;
    addr_t i_ic_addr;
    line_t o_ic_line;
    logic o_ic_done;
    logic i_dc_rd_req;
    addr_t i_dc_rd_addr;
    line_t o_dc_line;
    logic o_dc_done;
    logic i_dc_wb_req;
    addr_t i_dc_wb_addr;
    line_t i_dc_wb_line;
    logic o_dc_wb_done;
    logic o_bus_err;
    addr_t o_araddr;
    logic o_arvalid;
    logic [AXI_LEN_W-1:0] o_arlen;
    logic [2:0] o_arsize;
    axi_burst_t o_arburst;
    logic i_arready = 1'b0;
    word_t i_rdata = '0;
    axi_resp_t i_rresp = RESP_OKAY;
    logic i_rvalid = 1'b0;
    logic i_rlast = 1'b0;
    logic o_rready;
    addr_t o_awaddr;
    logic o_awvalid;
    logic [AXI_LEN_W-1:0] o_awlen;
    logic [2:0] o_awsize;
    axi_burst_t o_awburst;
    logic i_awready = 1'b0;
    word_t o_wdata;
    logic [AXI_STRB_W-1:0] o_wstrb;
    logic o_wlast;
    logic o_wvalid;
    logic i_wready = 1'b0;
    axi_resp_t i_bresp = RESP_OKAY;
    logic i_bvalid = 1'b0;
    logic o_bready;

    // slave model state
    word_t  mem [MEM_WORDS];
    addr_t  rd_addr;
    addr_t  wr_addr;
    int     rd_beat;
    int     wr_beat;
    word_t  rand_word;
    integer seed = 32'hc168_e268;
    int     cycle = 0;
    int     ar_cycle = 0;   // cycle of the latest AR handshake
    int     err_asked = 0;   // SLVERR bursts requested by tests
    int     err_used = 0;
    int     value_errs = 0;
    int     wait_errs = 0;
    int     proto_errs = 0;

    l1_miss_axi #(
        .LINE_WORDS (LINE_WORDS)
    ) l1_miss_axi_inst (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    function automatic idx_t word_idx(addr_t addr, int k);
        return addr[MEM_AW+1:2] + idx_t'(k);
    endfunction

    // slave model with ready stalls drawn from one random word per cycle
    always @(posedge clk) begin : axi_slave
        logic [31:0] r;
        if (!rstn) begin
            for (int i = 0; i < MEM_WORDS; i++)
                mem[i] <= word_t'(i * 4) ^ MEM_KEY;   // own byte address xor key
            i_arready <= 1'b0;
            i_rvalid  <= 1'b0;
            i_rlast   <= 1'b0;
            i_rresp   <= RESP_OKAY;
            i_awready <= 1'b0;
            i_wready  <= 1'b0;
            i_bvalid  <= 1'b0;
            i_bresp   <= RESP_OKAY;
            rd_beat   <= 0;
            wr_beat   <= 0;
        end else begin
            r = $random(seed);
            rand_word <= r;
            i_arready <= r[0] | r[1];   // ready about three cycles in four
            i_awready <= r[2] | r[3];
            i_wready  <= r[4] | r[5];
            if (o_arvalid && i_arready) begin
                if (o_arlen != AXI_LEN_W'(LINE_WORDS - 1) || o_arsize != SIZE_WORD ||
                        o_arburst != BURST_INCR) begin
                    proto_errs <= proto_errs + 1;
                    $display("AR request has wrong burst fields: len %0d size %0d burst %0d",
                             o_arlen, o_arsize, o_arburst);
                end
                ar_cycle <= cycle;
                rd_addr  <= o_araddr;
                rd_beat  <= 0;
                i_rvalid <= 1'b1;
                i_rdata  <= mem[word_idx(o_araddr, 0)];
                i_rlast  <= 1'b0;
                if (err_asked != err_used) begin
                    i_rresp  <= RESP_SLVERR;
                    err_used <= err_used + 1;
                end else begin
                    i_rresp <= RESP_OKAY;
                end
            end else if (i_rvalid && o_rready) begin
                if (i_rlast) begin
                    i_rvalid <= 1'b0;
                    i_rlast  <= 1'b0;
                    i_rresp  <= RESP_OKAY;
                end else begin
                    i_rdata <= mem[word_idx(rd_addr, rd_beat + 1)];
                    i_rlast <= (rd_beat + 1 == LINE_WORDS - 1);
                    rd_beat <= rd_beat + 1;
                end
            end
            if (o_awvalid && i_awready) begin
                if (o_awlen != AXI_LEN_W'(LINE_WORDS - 1) || o_awsize != SIZE_WORD ||
                        o_awburst != BURST_INCR) begin
                    proto_errs <= proto_errs + 1;
                    $display("AW request has wrong burst fields: len %0d size %0d burst %0d",
                             o_awlen, o_awsize, o_awburst);
                end
                wr_addr <= o_awaddr;
                wr_beat <= 0;
            end
            if (o_wvalid && i_wready) begin
                if (o_wstrb != '1 || o_wlast != (wr_beat == LINE_WORDS - 1)) begin
                    proto_errs <= proto_errs + 1;
                    $display("W beat %0d has wrong strobes or wlast", wr_beat);
                end
                mem[word_idx(wr_addr, wr_beat)] <= o_wdata;
                wr_beat <= wr_beat + 1;
                if (o_wlast) begin
                    i_bvalid <= 1'b1;
                    i_bresp  <= RESP_OKAY;
                end
            end
            if (i_bvalid && o_bready)
                i_bvalid <= 1'b0;
        end
    end

    function automatic line_t mem_line(addr_t addr);
        line_t line;
        line = '0;
        for (int k = 0; k < LINE_WORDS; k++)
            line = {mem[word_idx(addr, k)], line[LINE_W-1:AXI_DATA_W]};   // word 0 ends lowest
        return line;
    endfunction

    function automatic logic done_of(int which);
        case (which)
            DONE_IC: return o_ic_done;
            DONE_DC: return o_dc_done;
            default: return o_dc_wb_done;
        endcase
    endfunction

    task automatic check_line(input string name, input line_t expected, input line_t actual);
        if (actual !== expected) begin
            value_errs++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            value_errs++;
            $display("Fail %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rstn <= 1'b0;
        repeat (10) @(posedge clk);
        rstn <= 1'b1;
    endtask

    task automatic wait_done(input int which, input string what, output int at_cycle);
        bit seen;
        seen = 1'b0;
        at_cycle = -1;
        for (int n = 0; n < TEST_CYCLES && !seen; n++) begin
            @(posedge clk);
            if (done_of(which)) begin
                seen = 1'b1;
                at_cycle = cycle;
            end
        end
        if (!seen) begin
            wait_errs++;
            $display("no %s done pulse within %0d cycles", what, TEST_CYCLES);
        end
    endtask

    // request held until its done pulse and dropped on that edge
    task automatic read_line(input bit dcache, input addr_t addr, output int at_cycle);
        @(posedge clk);
        if (dcache) begin
            i_dc_rd_addr <= addr;
            i_dc_rd_req  <= 1'b1;
            wait_done(DONE_DC, "dcache fill", at_cycle);
            i_dc_rd_req  <= 1'b0;
        end else begin
            i_ic_addr <= addr;
            i_ic_req  <= 1'b1;
            wait_done(DONE_IC, "icache fill", at_cycle);
            i_ic_req  <= 1'b0;
        end
    endtask

    task automatic write_line(input addr_t addr, input line_t line, output int at_cycle);
        @(posedge clk);
        i_dc_wb_addr <= addr;
        i_dc_wb_line <= line;
        i_dc_wb_req  <= 1'b1;
        wait_done(DONE_WB, "writeback", at_cycle);
        i_dc_wb_req  <= 1'b0;
    endtask

    task automatic make_line(output line_t line);
        line = '0;
        repeat (LINE_WORDS) begin
            @(posedge clk);
            line = {rand_word, line[LINE_W-1:AXI_DATA_W]};
        end
    endtask

    task automatic test_icache_fill();
        int done_at;
        read_line(1'b0, 32'h0000_0100, done_at);
        check_line("icache fill", mem_line(32'h0000_0100), o_ic_line);
    endtask

    task automatic test_read_priority();
        int dc_at;
        int ic_at;
        fork
            read_line(1'b1, 32'h0000_0140, dc_at);
            read_line(1'b0, 32'h0000_01c0, ic_at);
        join
        check_flag("read priority dcache first", 1'b1, dc_at < ic_at);
        check_line("priority dcache line", mem_line(32'h0000_0140), o_dc_line);
        check_line("priority icache line", mem_line(32'h0000_01c0), o_ic_line);
    endtask

    task automatic test_writeback_read();
        line_t wb_line;
        int    done_at;
        make_line(wb_line);
        write_line(32'h0000_0200, wb_line, done_at);
        check_line("writeback into memory", wb_line, mem_line(32'h0000_0200));
        read_line(1'b1, 32'h0000_0200, done_at);
        check_line("read after writeback", wb_line, o_dc_line);
    endtask

    task automatic test_parallel();
        line_t wb_line;
        line_t fill_line;
        int    wb_at;
        int    ic_at;
        make_line(wb_line);
        fill_line = mem_line(32'h0000_0280);
        fork
            write_line(32'h0000_0300, wb_line, wb_at);
            read_line(1'b0, 32'h0000_0280, ic_at);
        join
        check_line("parallel writeback", wb_line, mem_line(32'h0000_0300));
        check_line("parallel icache fill", fill_line, o_ic_line);
        // the fill address goes out while the writeback is still open
        check_flag("fill issued before writeback done", 1'b1, ar_cycle < wb_at);
    endtask

    task automatic test_error_response();
        int done_at;
        check_flag("bus error before injection", 1'b0, o_bus_err);
        err_asked++;
        read_line(1'b0, 32'h0000_00c0, done_at);
        check_line("fill with slverr", mem_line(32'h0000_00c0), o_ic_line);
        repeat (2) @(posedge clk);   // error pulse then sticky flag
        check_flag("bus error raised", 1'b1, o_bus_err);
        repeat (20) @(posedge clk);
        check_flag("bus error sticky", 1'b1, o_bus_err);
        apply_reset();
        @(posedge clk);
        check_flag("bus error after reset", 1'b0, o_bus_err);
    endtask

    initial begin
        rstn         = 1'b0;
        i_ic_req     = 1'b0;
        i_ic_addr    = '0;
        i_dc_rd_req  = 1'b0;
        i_dc_rd_addr = '0;
        i_dc_wb_req  = 1'b0;
        i_dc_wb_addr = '0;
        i_dc_wb_line = '0;
        apply_reset();
        test_icache_fill();
        test_read_priority();
        test_writeback_read();
        test_parallel();
        test_error_response();
        $display("errors: %0d wrong values, %0d missing done pulses, %0d protocol",
                 value_errs, wait_errs, proto_errs);
        if (value_errs + wait_errs + proto_errs == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    // whole-run limit of one per-test bound for each test
    initial begin
        repeat (NUM_TESTS * TEST_CYCLES) @(posedge clk);
        $display("timeout: run still busy after %0d cycles", NUM_TESTS * TEST_CYCLES);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- l1_miss_axi.f
src/axi_bus_pkg.sv
src/cache_req_pkg.sv
src/beat_ifs.sv
src/axi_arbiter.sv
src/return_buffer.sv
src/write_buffer.sv
src/l1_miss_axi.sv
tests/axi_arbiter_properties.sv
tests/tb_l1_miss_axi.sv

//--- run.sh
#!/bin/sh
# build and run the miss path regression with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_l1_miss_axi -f l1_miss_axi.f -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -q "Regression passed"
